// ==== hdl/eth_rx_pkg.sv ====
package eth_rx_pkg;

    // xgmii control characters, valid only with rxc set on the lane
    localparam logic [7:0] RS_IDLE  = 8'h07;
    localparam logic [7:0] RS_START = 8'hFB;
    localparam logic [7:0] RS_TERM  = 8'hFD;

    // ethernet crc-32, lsb-first (reflected) form
    localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;
    localparam logic [31:0] CRC_POLY = 32'hEDB8_8320;

    // bytes of one frame, fcs included
    typedef logic [15:0] frame_len_t;

    // end-of-frame report, done is a single-cycle strobe
    typedef struct packed {
        logic       done;
        logic       crc_ok;
        frame_len_t length;
    } rx_frame_status_t;

    // running totals, all wrap
    typedef struct packed {
        logic [15:0] good_frames;
        logic [15:0] bad_frames;
        logic [31:0] octets;
    } rx_stats_t;

endpackage

// ==== hdl/eth_crc32.sv ====
`timescale 1ns/1ps

module eth_crc32 #(
    parameter int SLICE_LENGTH = 4
) (
    input  logic                      i_clk,
    input  logic                      i_clear,
    input  logic [SLICE_LENGTH*8-1:0] i_data,
    input  logic [SLICE_LENGTH-1:0]   i_valid,
    output logic [31:0]               o_crc
);
    import eth_rx_pkg::*;

    // running remainder, not inverted
    logic [31:0] crc_q;
    // remainder after the current word
    logic [31:0] crc_d;

    // one byte through the reflected polynomial, bit 0 first
    function automatic logic [31:0] crc_byte(
        input logic [31:0] crc_in,
        input logic [7:0]  data
    );
        logic [31:0] c;
        c = crc_in ^ {24'h00_0000, data};
        for (int b = 0; b < 8; b++) begin
            if (c[0]) begin
                c = (c >> 1) ^ CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    // lanes folded lowest first, so byte order on the wire is kept
    // invalid lanes are skipped, not zero-fed
    always_comb begin
        crc_d = crc_q;
        for (int i = 0; i < SLICE_LENGTH; i++) begin
            if (i_valid[i]) begin
                crc_d = crc_byte(crc_d, i_data[i*8 +: 8]);
            end
        end
    end

    // clear has priority, held high between frames
    always_ff @(posedge i_clk) begin
        if (i_clear) begin
            crc_q <= CRC_INIT;
        end else begin
            crc_q <= crc_d;
        end
    end

    // includes the current word, so the check lands on the same beat
    assign o_crc = ~crc_d;

endmodule

// ==== hdl/rx_mac.sv ====
`timescale 1ns/1ps

module rx_mac #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  logic [DATA_WIDTH-1:0]         i_xgmii_rxd,
    input  logic [DATA_WIDTH/8-1:0]       i_xgmii_rxc,
    input  logic                          i_phy_rx_valid,
    output logic [DATA_WIDTH-1:0]         o_axis_tdata,
    output logic [DATA_WIDTH/8-1:0]       o_axis_tkeep,
    output logic                          o_axis_tvalid,
    output logic                          o_axis_tlast,
    output logic                          o_axis_tuser,
    output eth_rx_pkg::rx_frame_status_t  o_status
);
    import eth_rx_pkg::*;

    localparam int NB    = DATA_WIDTH / 8;
    localparam int LANE_W = $clog2(NB);
    localparam int CNT_W = $clog2(NB + 1);

    typedef enum logic {ST_IDLE, ST_DATA} state_t;
    state_t state_q;

    // start detect
    logic          start_0, start_4, start_found;
    logic          start_del_q, start_lane4_q;
    logic [NB-1:0] start_keep;

    // terminate detect
    logic [NB-1:0]     term_loc, term_keep;
    logic              term_found;
    logic [LANE_W-1:0] term_lane;

    // crc path, runs four bytes behind the wire
    logic [DATA_WIDTH-1:0]  rxd_del_q;
    logic [NB-1:0]          keep_del_q;
    logic [DATA_WIDTH+31:0] pend_data;
    logic [NB+3:0]          pend_keep;
    logic [NB-1:0]          crc_valid;
    logic                   crc_clear;
    logic [31:0]            calc_crc, rx_fcs;

    // frame length
    logic [CNT_W-1:0] beat_bytes;
    frame_len_t       len_q, frame_len;

    // lane 0 start is legal on both widths
    assign start_0 = i_phy_rx_valid && i_xgmii_rxc[0] && (i_xgmii_rxd[7:0] == RS_START);

    generate
        if (NB == 8) begin : g_wide
            logic low_idle;
            // lane 4 start only after idle filler in the lower half
            assign low_idle = (&i_xgmii_rxc[3:0]) && (i_xgmii_rxd[31:0] == {4{RS_IDLE}});
            assign start_4 = i_phy_rx_valid && low_idle && i_xgmii_rxc[4]
                             && (i_xgmii_rxd[39:32] == RS_START);
            // lane 4 start leaves preamble and sfd in the lower half of the next beat
            assign start_keep = {4'hF, {4{!start_lane4_q}}};
        end else begin : g_narrow
            assign start_4 = 1'b0;
            // next beat is 55 55 55 d5, nothing to keep
            assign start_keep = '0;
        end
    endgenerate

    assign start_found = start_0 || start_4;

    // per-lane terminate scan, keep covers lanes below the first hit
    always_comb begin
        logic seen;
        seen      = 1'b0;
        term_lane = '0;
        for (int i = 0; i < NB; i++) begin
            term_loc[i] = i_phy_rx_valid && i_xgmii_rxc[i]
                          && (i_xgmii_rxd[i*8 +: 8] == RS_TERM);
            if (term_loc[i] && !seen) begin
                term_lane = LANE_W'(i);
            end
            seen         = seen || term_loc[i];
            term_keep[i] = !seen;
        end
    end

    assign term_found = |term_loc;

    // stream port, straight from the phy word
    assign o_axis_tdata = i_xgmii_rxd;

    always_comb begin
        o_axis_tvalid = 1'b0;
        o_axis_tlast  = 1'b0;
        o_axis_tkeep  = '0;
        if (i_phy_rx_valid && (state_q == ST_DATA)) begin
            if (start_del_q) begin
                o_axis_tkeep  = start_keep;
                o_axis_tvalid = |start_keep;
            end else if (term_found) begin
                // may be keep zero when the terminate sits in lane 0
                o_axis_tkeep  = term_keep;
                o_axis_tvalid = 1'b1;
                o_axis_tlast  = 1'b1;
            end else begin
                o_axis_tkeep  = '1;
                o_axis_tvalid = 1'b1;
            end
        end
    end

    // fsm and start bookkeeping, frozen while the phy strobe is low
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q       <= ST_IDLE;
            start_del_q   <= 1'b0;
            start_lane4_q <= 1'b0;
            keep_del_q    <= '0;
        end else if (i_phy_rx_valid) begin
            start_del_q   <= (state_q == ST_IDLE) && start_found;
            start_lane4_q <= start_4;
            keep_del_q    <= o_axis_tkeep;
            if ((state_q == ST_IDLE) && start_found) begin
                state_q <= ST_DATA;
            end else if (o_axis_tlast) begin
                state_q <= ST_IDLE;
            end
        end
    end

    // previous word, holds the fcs bytes until the terminate shows up
    always_ff @(posedge i_clk) begin
        if (i_phy_rx_valid) begin
            rxd_del_q <= i_xgmii_rxd;
        end
    end

    // unfed bytes: upper four of the old word, then the current word
    assign pend_data = {i_xgmii_rxd, rxd_del_q[DATA_WIDTH-1 -: 32]};
    assign pend_keep = {o_axis_tkeep, keep_del_q[NB-1 -: 4]};

    // on the last beat the last four pending bytes are the fcs,
    // which leaves exactly the lanes below the terminate for the crc
    always_comb begin
        if (!i_phy_rx_valid) begin
            crc_valid = '0;
        end else if (o_axis_tlast) begin
            crc_valid = term_keep;
        end else begin
            crc_valid = pend_keep[NB-1:0];
        end
    end

    // fcs arrives lsb first
    assign rx_fcs    = pend_data[term_lane*8 +: 32];
    assign crc_clear = (state_q == ST_IDLE);

    eth_crc32 #(
        .SLICE_LENGTH(NB)
    ) u_crc (
        .i_clk   (i_clk),
        .i_clear (crc_clear),
        .i_data  (pend_data[DATA_WIDTH-1:0]),
        .i_valid (crc_valid),
        .o_crc   (calc_crc)
    );

    assign o_axis_tuser = o_axis_tlast && (calc_crc == rx_fcs);

    // kept bytes so far, fcs included
    assign beat_bytes = CNT_W'($countones(o_axis_tkeep));
    assign frame_len  = len_q + frame_len_t'(beat_bytes);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            len_q <= '0;
        end else if (o_axis_tvalid) begin
            len_q <= o_axis_tlast ? '0 : frame_len;
        end
    end

    // status one cycle after tlast, done is a pulse
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_status <= '0;
        end else begin
            o_status.done   <= o_axis_tlast;
            o_status.crc_ok <= o_axis_tuser;
            o_status.length <= frame_len;
        end
    end

endmodule

// ==== hdl/rx_frame_stats.sv ====
`timescale 1ns/1ps

module rx_frame_stats (
    input  logic                         i_clk,
    input  logic                         i_reset,
    input  eth_rx_pkg::rx_frame_status_t i_status,
    output eth_rx_pkg::rx_frame_status_t o_status,
    output eth_rx_pkg::rx_stats_t        o_stats
);
    import eth_rx_pkg::*;

    // status copy, done stays a single pulse
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_status <= '0;
        end else begin
            o_status.done <= i_status.done;
            // record fields only on a completed frame
            if (i_status.done) begin
                o_status.crc_ok <= i_status.crc_ok;
                o_status.length <= i_status.length;
            end
        end
    end

    // counters move together with the status copy
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_stats <= '0;
        end else if (i_status.done) begin
            if (i_status.crc_ok) begin
                o_stats.good_frames <= o_stats.good_frames + 16'd1;
            end else begin
                o_stats.bad_frames <= o_stats.bad_frames + 16'd1;
            end
            // bad frames count octets too
            o_stats.octets <= o_stats.octets + 32'(i_status.length);
        end
    end

endmodule

// ==== hdl/eth_rx_top.sv ====
`timescale 1ns/1ps

module eth_rx_top #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                         i_clk,
    input  logic                         i_reset,
    input  logic [DATA_WIDTH-1:0]        i_xgmii_rxd,
    input  logic [DATA_WIDTH/8-1:0]      i_xgmii_rxc,
    input  logic                         i_phy_rx_valid,
    output logic [DATA_WIDTH-1:0]        o_axis_tdata,
    output logic [DATA_WIDTH/8-1:0]      o_axis_tkeep,
    output logic                         o_axis_tvalid,
    output logic                         o_axis_tlast,
    output logic                         o_axis_tuser,
    output eth_rx_pkg::rx_frame_status_t o_status,
    output eth_rx_pkg::rx_stats_t        o_stats
);
    import eth_rx_pkg::*;

    // per-frame pulse from the mac
    rx_frame_status_t mac_status;

    rx_mac #(
        .DATA_WIDTH(DATA_WIDTH)
    ) u_rx_mac (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_xgmii_rxd    (i_xgmii_rxd),
        .i_xgmii_rxc    (i_xgmii_rxc),
        .i_phy_rx_valid (i_phy_rx_valid),
        .o_axis_tdata   (o_axis_tdata),
        .o_axis_tkeep   (o_axis_tkeep),
        .o_axis_tvalid  (o_axis_tvalid),
        .o_axis_tlast   (o_axis_tlast),
        .o_axis_tuser   (o_axis_tuser),
        .o_status       (mac_status)
    );

    // registered status and counters, one more cycle
    rx_frame_stats u_rx_frame_stats (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_status (mac_status),
        .o_status (o_status),
        .o_stats  (o_stats)
    );

endmodule

// ==== tests/eth_rx_checker.sv ====
`timescale 1ns/1ps

module eth_rx_checker #(
    parameter int DATA_WIDTH = 32
) (
    input logic                         i_clk,
    input logic                         i_reset,
    input logic                         i_phy_rx_valid,
    input logic [DATA_WIDTH/8-1:0]      i_tkeep,
    input logic                         i_tvalid,
    input logic                         i_tlast,
    input logic                         i_tuser,
    input eth_rx_pkg::rx_frame_status_t i_status
);

    // number of assertion failures so far
    int fail_count = 0;

    // no stray keep bits on idle cycles
    keep_idle: assert property (@(posedge i_clk) disable iff (i_reset)
        !i_tvalid |-> (i_tkeep == '0))
        else begin
            $error("tkeep set while tvalid is low");
            fail_count++;
        end

    // crc flag only meaningful on the last beat
    user_last: assert property (@(posedge i_clk) disable iff (i_reset)
        i_tuser |-> i_tlast)
        else begin
            $error("tuser high without tlast");
            fail_count++;
        end

    // status pulse exactly one cycle behind tlast in both directions
    done_after_last: assert property (@(posedge i_clk) disable iff (i_reset)
        i_tlast |=> i_status.done)
        else begin
            $error("no status done after tlast");
            fail_count++;
        end
    done_only_after_last: assert property (@(posedge i_clk) disable iff (i_reset)
        i_status.done |-> $past(i_tlast))
        else begin
            $error("status done without tlast");
            fail_count++;
        end

    // gap cycles never produce a beat
    valid_gap: assert property (@(posedge i_clk) disable iff (i_reset)
        !i_phy_rx_valid |-> !i_tvalid)
        else begin
            $error("tvalid high while phy valid is low");
            fail_count++;
        end

endmodule

bind rx_mac eth_rx_checker #(
    .DATA_WIDTH(DATA_WIDTH)
) u_checker (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_phy_rx_valid (i_phy_rx_valid),
    .i_tkeep        (o_axis_tkeep),
    .i_tvalid       (o_axis_tvalid),
    .i_tlast        (o_axis_tlast),
    .i_tuser        (o_axis_tuser),
    .i_status       (o_status)
);

// ==== tests/eth_rx_tb.sv ====
`timescale 1ns/1ps

module eth_rx_tb;
    import eth_rx_pkg::*;

    logic             i_clk;
    logic             i_reset;
    logic [31:0]      i_xgmii_rxd;
    logic [3:0]       i_xgmii_rxc;
    logic             i_phy_rx_valid;
    logic [31:0]      o_axis_tdata;
    logic [3:0]       o_axis_tkeep;
    logic             o_axis_tvalid;
    logic             o_axis_tlast;
    logic             o_axis_tuser;
    rx_frame_status_t o_status;
    rx_stats_t        o_stats;

    int               errors;
    int               tests;
    // checker failures already folded into errors
    int               assert_fails;
    logic [31:0]      lcg_state = 32'd39;
    // payload plus fcs as sent and the bytes seen on the stream
    logic [7:0]       exp_bytes[$];
    logic [7:0]       rx_bytes[$];
    logic             last_seen;
    logic             last_user;
    logic             status_seen;
    rx_frame_status_t seen_status;
    rx_stats_t        exp_stats;

    eth_rx_top #(
        .DATA_WIDTH(32)
    ) UUT (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_xgmii_rxd    (i_xgmii_rxd),
        .i_xgmii_rxc    (i_xgmii_rxc),
        .i_phy_rx_valid (i_phy_rx_valid),
        .o_axis_tdata   (o_axis_tdata),
        .o_axis_tkeep   (o_axis_tkeep),
        .o_axis_tvalid  (o_axis_tvalid),
        .o_axis_tlast   (o_axis_tlast),
        .o_axis_tuser   (o_axis_tuser),
        .o_status       (o_status),
        .o_stats        (o_stats)
    );

    initial i_clk = 1'b0;
    always #2 i_clk = ~i_clk;

    // sample mid low phase once inputs and state have settled
    always begin
        @(negedge i_clk);
        #1;
        if (o_axis_tvalid) begin
            for (int i = 0; i < 4; i++) begin
                if (o_axis_tkeep[i]) begin
                    rx_bytes.push_back(o_axis_tdata[i*8 +: 8]);
                end
            end
            if (o_axis_tlast) begin
                last_seen = 1'b1;
                last_user = o_axis_tuser;
            end
        end
        if (o_status.done) begin
            status_seen = 1'b1;
            seen_status = o_status;
        end
    end

    function automatic logic [7:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    // bit-serial crc-32 taking the lsb of each byte first
    function automatic logic [31:0] ref_crc(input logic [7:0] data[$]);
        logic [31:0] c;
        logic        fb;
        c = CRC_INIT;
        foreach (data[i]) begin
            for (int b = 0; b < 8; b++) begin
                fb = c[0] ^ data[i][b];
                c  = c >> 1;
                if (fb) begin
                    c = c ^ CRC_POLY;
                end
            end
        end
        return ~c;
    endfunction

    task automatic drive_word(input logic [31:0] data, input logic [3:0] ctl,
                              input logic valid);
        @(negedge i_clk);
        i_xgmii_rxd    = data;
        i_xgmii_rxc    = ctl;
        i_phy_rx_valid = valid;
    endtask

    task automatic drive_idle();
        drive_word({4{RS_IDLE}}, 4'hF, 1'b1);
    endtask

    // zero to three strobe-low cycles with junk on the bus
    task automatic insert_gaps();
        int n;
        n = next_random() % 4;
        repeat (n) begin
            drive_word({next_random(), next_random(), next_random(), next_random()},
                       4'h0, 1'b0);
        end
    endtask

    task automatic wait_last();
        int t;
        t = 0;
        while (!last_seen && t < 20) begin
            drive_idle();
            t++;
        end
        if (!last_seen) begin
            $display("timeout at %0t: tlast never came", $time);
            errors++;
        end
    endtask

    task automatic wait_status();
        int t;
        t = 0;
        while (!status_seen && t < 20) begin
            drive_idle();
            t++;
        end
        if (!status_seen) begin
            $display("timeout at %0t: no status pulse after the frame", $time);
            errors++;
        end
    endtask

    // nonzero cut stops after that many words and skips the waits
    task automatic run_frame(input int len, input bit corrupt, input bit gaps,
                             input int cut);
        logic [7:0]  payload[$];
        logic [8:0]  lanes[$];
        logic [31:0] fcs;
        logic [31:0] w;
        logic [3:0]  c;
        rx_bytes.delete();
        last_seen   = 1'b0;
        status_seen = 1'b0;
        for (int i = 0; i < len; i++) begin
            payload.push_back(next_random());
        end
        fcs = ref_crc(payload);
        if (corrupt) begin
            payload[len / 2] = payload[len / 2] ^ 8'h10;
        end
        exp_bytes = payload;
        for (int i = 0; i < 4; i++) begin
            exp_bytes.push_back(fcs[i*8 +: 8]);
        end
        // {ctl, byte} per lane
        lanes.push_back({1'b1, RS_START});
        for (int i = 0; i < 6; i++) begin
            lanes.push_back(9'h055);
        end
        lanes.push_back(9'h0D5);
        foreach (exp_bytes[i]) begin
            lanes.push_back({1'b0, exp_bytes[i]});
        end
        lanes.push_back({1'b1, RS_TERM});
        while (lanes.size() % 4 != 0) begin
            lanes.push_back({1'b1, RS_IDLE});
        end
        for (int k = 0; k < lanes.size(); k += 4) begin
            if (cut != 0 && k / 4 >= cut) begin
                break;
            end
            if (gaps) begin
                insert_gaps();
            end
            for (int j = 0; j < 4; j++) begin
                w[j*8 +: 8] = lanes[k + j][7:0];
                c[j]        = lanes[k + j][8];
            end
            drive_word(w, c, 1'b1);
        end
        if (cut == 0) begin
            wait_last();
            wait_status();
            if (corrupt) begin
                exp_stats.bad_frames = exp_stats.bad_frames + 16'd1;
            end else begin
                exp_stats.good_frames = exp_stats.good_frames + 16'd1;
            end
            exp_stats.octets = exp_stats.octets + 32'(len + 4);
        end
    endtask

    task automatic check_bytes(input string name);
        bit bad;
        bad = 1'b0;
        if (rx_bytes.size() != exp_bytes.size()) begin
            $display("Mismatch at %0t: %s got %0d bytes, expected %0d", $time, name,
                     rx_bytes.size(), exp_bytes.size());
            errors++;
        end else begin
            foreach (exp_bytes[i]) begin
                if (!bad && rx_bytes[i] !== exp_bytes[i]) begin
                    $display("Mismatch at %0t: %s byte %0d is %h, expected %h", $time,
                             name, i, rx_bytes[i], exp_bytes[i]);
                    errors++;
                    bad = 1'b1;
                end
            end
        end
    endtask

    task automatic check_flag(input logic exp, input logic got, input string name);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s tuser %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_status(input rx_frame_status_t exp, input string name);
        if (seen_status !== exp) begin
            $display("Mismatch at %0t: %s status %h, expected %h", $time, name,
                     seen_status, exp);
            errors++;
        end
    endtask

    task automatic check_stats(input rx_stats_t exp, input string name);
        if (o_stats !== exp) begin
            $display("Mismatch at %0t: %s stats %h, expected %h", $time, name,
                     o_stats, exp);
            errors++;
        end
    endtask

    // bytes, tuser and status of the frame just received
    task automatic check_frame(input int len, input logic good, input string name);
        rx_frame_status_t exp;
        exp.done   = 1'b1;
        exp.crc_ok = good;
        exp.length = frame_len_t'(len + 4);
        check_bytes(name);
        check_flag(good, last_user, name);
        check_status(exp, name);
    endtask

    // new failures of the bound assertions count as errors
    task automatic fold_assert_fails();
        int n;
        n = UUT.u_rx_mac.u_checker.fail_count;
        errors       = errors + (n - assert_fails);
        assert_fails = n;
    endtask

    task automatic report_test(input string name, input int e0);
        fold_assert_fails();
        tests++;
        $display("%s: %s", name, (errors == e0) ? "ok" : "failed");
    endtask

    task automatic good_frame();
        int e0;
        e0 = errors;
        run_frame(64, 1'b0, 1'b0, 0);
        check_frame(64, 1'b1, "good frame");
        report_test("good frame", e0);
    endtask

    // 68..71 puts the terminate in lanes 0..3
    task automatic terminate_lanes();
        int e0;
        e0 = errors;
        for (int l = 0; l < 4; l++) begin
            run_frame(68 + l, 1'b0, 1'b0, 0);
            check_frame(68 + l, 1'b1, $sformatf("terminate lane %0d", l));
        end
        report_test("terminate lanes", e0);
    endtask

    task automatic corrupted_fcs();
        int e0;
        e0 = errors;
        run_frame(50, 1'b1, 1'b0, 0);
        check_frame(50, 1'b0, "corrupted fcs");
        report_test("corrupted fcs", e0);
    endtask

    task automatic valid_gaps();
        int e0;
        e0 = errors;
        run_frame(80, 1'b0, 1'b1, 0);
        check_frame(80, 1'b1, "valid gaps");
        report_test("valid gaps", e0);
    endtask

    // counters carry everything since the last reset
    task automatic statistics_run();
        int e0;
        e0 = errors;
        run_frame(40, 1'b0, 1'b0, 0);
        check_frame(40, 1'b1, "stats frame a");
        run_frame(45, 1'b1, 1'b1, 0);
        check_frame(45, 1'b0, "stats frame b");
        run_frame(46, 1'b0, 1'b0, 0);
        check_frame(46, 1'b1, "stats frame c");
        check_stats(exp_stats, "statistics");
        report_test("statistics", e0);
    endtask

    task automatic reset_mid_frame();
        int e0;
        e0 = errors;
        run_frame(60, 1'b0, 1'b0, 5);
        i_reset = 1'b1;
        repeat (5) begin
            drive_idle();
        end
        i_reset   = 1'b0;
        exp_stats = '0;
        drive_idle();
        check_stats(exp_stats, "after reset");
        run_frame(60, 1'b0, 1'b0, 0);
        check_frame(60, 1'b1, "frame after reset");
        check_stats(exp_stats, "stats after reset");
        report_test("reset mid frame", e0);
    endtask

    initial begin
        i_reset        = 1'b1;
        i_xgmii_rxd    = {4{RS_IDLE}};
        i_xgmii_rxc    = 4'hF;
        i_phy_rx_valid = 1'b1;
        errors         = 0;
        tests          = 0;
        assert_fails   = 0;
        last_seen      = 1'b0;
        last_user      = 1'b0;
        status_seen    = 1'b0;
        seen_status    = '0;
        exp_stats      = '0;
        repeat (5) @(posedge i_clk);
        @(negedge i_clk);
        i_reset = 1'b0;
        repeat (4) begin
            drive_idle();
        end
        good_frame();
        terminate_lanes();
        corrupted_fcs();
        valid_gaps();
        statistics_run();
        reset_mid_frame();
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== eth_rx.f ====
hdl/eth_rx_pkg.sv
hdl/eth_crc32.sv
hdl/rx_mac.sv
hdl/rx_frame_stats.sv
hdl/eth_rx_top.sv
tests/eth_rx_checker.sv
tests/eth_rx_tb.sv

// ==== Bender.yml ====
package:
  name: eth_rx

sources:
  - hdl/eth_rx_pkg.sv
  - hdl/eth_crc32.sv
  - hdl/rx_mac.sv
  - hdl/rx_frame_stats.sv
  - hdl/eth_rx_top.sv
  - target: test
    files:
      - tests/eth_rx_checker.sv
      - tests/eth_rx_tb.sv
